// File: Makefile
TOP := tb_pcap_replay
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	verilator --lint-only --assert -I. replay_pkg.sv pcap_capture.sv pcap_mem.sv \
	  replay_reader.sv replay_fifo.sv pcap_replay_top.sv --top-module pcap_replay_top

clean:
	rm -rf obj_dir $(LOG)

// File: pcap_capture.sv
// Capture writer that records input beats and closes the trace with a marker
`timescale 1ns/100ps
`include "replay_defs.svh"

module pcap_capture (
  input  logic                      axis_aclk,
  input  logic                      axis_aresetn,
  input  logic                      sw_rst,
  input  logic                      wr_done,
  input  replay_pkg::pcap_beat_t    s_axis_beat,
  input  logic                      s_axis_tvalid,
  output logic                      s_axis_tready,
  output logic                      wr_en,
  output logic [`REPLAY_ADDR_W-1:0] wr_addr,
  output replay_pkg::mem_entry_t    wr_entry
);
  import replay_pkg::*;

  capture_state_t            state;
  logic [`REPLAY_ADDR_W-1:0] next_addr;
  logic                      beat_fire;
  logic                      close_trace;

  assign s_axis_tready = (state != CAP_DONE);
  assign beat_fire     = s_axis_tvalid && s_axis_tready;
  // wr_done wins over a beat in the same cycle
  assign close_trace   = (state == CAP_REC) && wr_done;

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || sw_rst) begin
      state     <= CAP_IDLE;
      next_addr <= '0;
      wr_en     <= 1'b0;
    end else begin
      wr_en <= beat_fire || close_trace;
      case (state)
        CAP_IDLE: begin
          // Address is 0 here, first beat opens a new trace
          if (beat_fire) begin
            state     <= CAP_REC;
            next_addr <= next_addr + 1'b1;
          end
        end
        CAP_REC: begin
          if (close_trace) begin
            state <= CAP_DONE;
          end else if (beat_fire) begin
            next_addr <= next_addr + 1'b1;
          end
        end
        default: begin
          state     <= CAP_IDLE;
          next_addr <= '0;
        end
      endcase
    end
  end

  // Write port registers
  always_ff @(posedge axis_aclk) begin
    wr_addr        <= next_addr;
    wr_entry.valid <= 1'b1;
    wr_entry.eot   <= close_trace;
    wr_entry.beat  <= close_trace ? pcap_beat_t'(0) : s_axis_beat;
  end

  a_no_wr_done_in_cap_done: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    state == CAP_DONE |-> !wr_done);

  // Trace plus marker must fit, a wrap would overwrite the first beat
  a_no_wrap_in_cap_rec: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    state == CAP_REC |-> next_addr != '0);

endmodule

// File: pcap_mem.sv
// Single-port packet memory with registered read and write priority
`timescale 1ns/100ps
`include "replay_defs.svh"

module pcap_mem (
  input  logic                      axis_aclk,
  input  logic                      wr_en,
  input  logic [`REPLAY_ADDR_W-1:0] wr_addr,
  input  replay_pkg::mem_entry_t    wr_entry,
  input  logic                      rd_en,
  input  logic [`REPLAY_ADDR_W-1:0] rd_addr,
  output replay_pkg::mem_entry_t    rd_entry,
  output logic                      rd_valid
);
  import replay_pkg::*;

  localparam int DEPTH = 1 << `REPLAY_ADDR_W;

  mem_entry_t                mem [DEPTH];
  logic [`REPLAY_ADDR_W-1:0] addr;

  // One shared address, the writer owns it when active
  assign addr = wr_en ? wr_addr : rd_addr;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[addr] <= wr_entry;
    end else if (rd_en) begin
      rd_entry <= mem[addr];
    end
  end

  always_ff @(posedge axis_aclk) begin
    rd_valid <= rd_en;
  end

  // Replay and recording must never overlap, the read would be lost
  a_no_rd_wr_collision: assert property (@(posedge axis_aclk) !(wr_en && rd_en));

endmodule

// File: pcap_replay_top.sv
// Capture-and-replay engine for one stream port
`timescale 1ns/100ps
`include "replay_defs.svh"

module pcap_replay_top (
  input  logic                       axis_aclk,
  input  logic                       axis_aresetn,
  input  logic                       sw_rst,
  input  logic                       wr_done,
  input  logic                       replay_start,
  input  logic [`REPLAY_COUNT_W-1:0] replay_count,
  input  replay_pkg::pcap_beat_t     s_axis_beat,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  output replay_pkg::pcap_beat_t     m_axis_beat,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic                       replay_busy
);
  import replay_pkg::*;

  logic                      wr_en;
  logic [`REPLAY_ADDR_W-1:0] wr_addr;
  mem_entry_t                wr_entry;
  logic                      rd_en;
  logic [`REPLAY_ADDR_W-1:0] rd_addr;
  mem_entry_t                rd_entry;
  logic                      rd_valid;
  logic                      nearly_full;
  logic                      push;
  pcap_beat_t                push_beat;

  pcap_capture u_capture (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .sw_rst        (sw_rst),
    .wr_done       (wr_done),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_entry      (wr_entry)
  );

  pcap_mem u_mem (
    .axis_aclk (axis_aclk),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_entry  (wr_entry),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_entry  (rd_entry),
    .rd_valid  (rd_valid)
  );

  replay_reader u_reader (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .sw_rst       (sw_rst),
    .replay_start (replay_start),
    .replay_count (replay_count),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_entry     (rd_entry),
    .rd_valid     (rd_valid),
    .nearly_full  (nearly_full),
    .push         (push),
    .push_beat    (push_beat),
    .replay_busy  (replay_busy)
  );

  replay_fifo u_fifo (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .push          (push),
    .push_beat     (push_beat),
    .nearly_full   (nearly_full),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

// File: replay_defs.svh
// Widths and depths shared by the capture-and-replay engine
`ifndef REPLAY_DEFS_SVH
`define REPLAY_DEFS_SVH

// Stream beat payload
`define REPLAY_DATA_W 64
`define REPLAY_KEEP_W 8

// 256-entry packet memory
`define REPLAY_ADDR_W 8

// Number of replay passes
`define REPLAY_COUNT_W 16

// Output FIFO of 16 entries
`define REPLAY_FIFO_DEPTH_BITS 4

// Free entries left when nearly-full rises, covers reads in flight
`define REPLAY_FIFO_SLACK 2

`endif

// File: replay_fifo.sv
// Fall-through output FIFO with a nearly-full flag that throttles reads
`timescale 1ns/100ps
`include "replay_defs.svh"

module replay_fifo (
  input  logic                   axis_aclk,
  input  logic                   axis_aresetn,
  input  logic                   push,
  input  replay_pkg::pcap_beat_t push_beat,
  output logic                   nearly_full,
  output replay_pkg::pcap_beat_t m_axis_beat,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready
);
  import replay_pkg::*;

  localparam int PTR_W = `REPLAY_FIFO_DEPTH_BITS;
  localparam int DEPTH = 1 << PTR_W;
  localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(DEPTH);
  localparam logic [PTR_W:0] NF_LEVEL   = (PTR_W + 1)'(DEPTH - `REPLAY_FIFO_SLACK);

  pcap_beat_t       slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;

  // Head entry is presented without a read cycle
  assign m_axis_tvalid = (count != '0);
  assign m_axis_beat   = slots[rd_ptr];
  assign pop           = m_axis_tvalid && m_axis_tready;
  assign nearly_full   = (count >= NF_LEVEL);

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      slots[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader throttling must keep the buffer from overflowing
  a_no_push_when_full: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    push |-> count != FULL_LEVEL);

endmodule

// File: replay_pkg.sv
// Types shared by the capture-and-replay engine
`include "replay_defs.svh"

package replay_pkg;

  // One stream beat as carried on the input and output streams
  typedef struct packed {
    logic [`REPLAY_DATA_W-1:0] tdata;
    logic [`REPLAY_KEEP_W-1:0] tkeep;
    logic                      tlast;
  } pcap_beat_t;

  // Packet memory word
  typedef struct packed {
    logic       valid;
    logic       eot;
    pcap_beat_t beat;
  } mem_entry_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_REC,
    CAP_DONE
  } capture_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_RUN
  } replay_state_t;

endpackage

// File: replay_reader.sv
// Replay reader that walks the stored trace and feeds the output FIFO
`timescale 1ns/100ps
`include "replay_defs.svh"

module replay_reader (
  input  logic                       axis_aclk,
  input  logic                       axis_aresetn,
  input  logic                       sw_rst,
  input  logic                       replay_start,
  input  logic [`REPLAY_COUNT_W-1:0] replay_count,
  output logic                       rd_en,
  output logic [`REPLAY_ADDR_W-1:0]  rd_addr,
  input  replay_pkg::mem_entry_t     rd_entry,
  input  logic                       rd_valid,
  input  logic                       nearly_full,
  output logic                       push,
  output replay_pkg::pcap_beat_t     push_beat,
  output logic                       replay_busy
);
  import replay_pkg::*;

  replay_state_t              state;
  logic                       start_q;
  logic                       start_edge;
  logic [`REPLAY_COUNT_W-1:0] pass_cnt;
  logic                       epoch;
  logic                       rd_epoch;
  logic                       ret_hit;
  logic                       marker_hit;
  logic                       last_pass;
  logic [1:0]                 nf_pushes;

  assign start_edge  = replay_start && !start_q;
  assign rd_en       = (state == RD_RUN) && !nearly_full;
  assign replay_busy = (state == RD_RUN);

  // Returns tagged with a stale epoch were issued past a marker
  assign ret_hit    = rd_valid && (rd_epoch == epoch) && (state == RD_RUN);
  assign marker_hit = ret_hit && rd_entry.eot;
  assign last_pass  = (pass_cnt + 1'b1) == replay_count;
  assign push       = ret_hit && rd_entry.valid && !rd_entry.eot;
  assign push_beat  = rd_entry.beat;

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      start_q <= 1'b0;
    end else begin
      start_q <= replay_start;
    end
  end

  // Epoch follows each read through the memory latency
  always_ff @(posedge axis_aclk) begin
    rd_epoch <= epoch;
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || sw_rst) begin
      state    <= RD_IDLE;
      rd_addr  <= '0;
      pass_cnt <= '0;
      epoch    <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (start_edge && (replay_count != '0)) begin
            state    <= RD_RUN;
            rd_addr  <= '0;
            pass_cnt <= '0;
          end
        end
        default: begin
          if (marker_hit) begin
            epoch   <= ~epoch;
            rd_addr <= '0;
            if (last_pass) begin
              state <= RD_IDLE;
            end else begin
              pass_cnt <= pass_cnt + 1'b1;
            end
          end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
      endcase
    end
  end

  // Pushes seen while the FIFO stays nearly full
  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || !nearly_full) begin
      nf_pushes <= '0;
    end else if (push && (nf_pushes != 2'd3)) begin
      nf_pushes <= nf_pushes + 1'b1;
    end
  end

  // Only reads already in flight may land after nearly-full rises
  a_push_within_slack: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    nf_pushes <= `REPLAY_FIFO_SLACK);

endmodule

// File: tb.f
+incdir+.
replay_pkg.sv
pcap_capture.sv
pcap_mem.sv
replay_reader.sv
replay_fifo.sv
pcap_replay_top.sv
tb_pcap_replay.sv

// File: tb_pcap_replay.sv
// Testbench for the capture-and-replay engine with scoreboard and assertions
`timescale 1ns/100ps
`include "replay_defs.svh"

module tb_pcap_replay;
  import replay_pkg::*;

  // Watchdog budget of (beats x passes x 8 + 200) cycles per test
  localparam int WATCHDOG_CYCLES = 200 + (5 * 1 * 8 + 200) + (5 * 3 * 8 + 200) +
                                   (12 * 4 * 8 + 200) + 200 + (12 * 4 * 8 + 200) +
                                   (3 * 1 * 8 + 200);

  logic                       axis_aclk;
  logic                       axis_aresetn;
  logic                       sw_rst;
  logic                       wr_done;
  logic                       replay_start;
  logic [`REPLAY_COUNT_W-1:0] replay_count;
  pcap_beat_t                 s_axis_beat;
  logic                       s_axis_tvalid;
  logic                       s_axis_tready;
  pcap_beat_t                 m_axis_beat;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready;
  logic                       replay_busy;

  pcap_beat_t rec_q[$];
  pcap_beat_t exp_q[$];
  string      cur_test;
  int         errors;
  int         test_errors_at_start;
  int         tests_run;
  int         tests_failed;
  int         drained;
  logic       draining;
  logic       expect_idle;
  // 0 holds ready low, 1 holds it high, 2 randomizes it
  int         ready_mode;

  pcap_replay_top u_pcap_replay_top (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .sw_rst        (sw_rst),
    .wr_done       (wr_done),
    .replay_start  (replay_start),
    .replay_count  (replay_count),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .replay_busy   (replay_busy)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #2 axis_aclk = ~axis_aclk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge axis_aclk);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
    $display("Finished with errors");
    $finish;
  end

  always @(posedge axis_aclk) begin
    #1;
    case (ready_mode)
      0:       m_axis_tready <= 1'b0;
      1:       m_axis_tready <= 1'b1;
      default: m_axis_tready <= 1'($urandom % 2);
    endcase
  end

  // Transfers judged at the falling edge before the edge that takes them
  always @(negedge axis_aclk) begin
    pcap_beat_t exp_beat;
    if (axis_aresetn && m_axis_tvalid && m_axis_tready) begin
      if (draining) begin
        drained++;
      end else if (exp_q.size() == 0) begin
        $display("%s: an output beat appeared when none was expected", cur_test);
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        assert (m_axis_beat === exp_beat) else begin
          $display("** Error: %s expected %h actual %h", cur_test, exp_beat, m_axis_beat);
          errors++;
        end
      end
    end
  end

  a_hold_under_backpressure: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_beat))
  else begin
    $display("%s: output beat changed while stalled", cur_test);
    errors++;
  end

  a_idle_on_zero_count: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    expect_idle |-> !replay_busy && !m_axis_tvalid)
  else begin
    $display("%s: replay became active with a count of zero", cur_test);
    errors++;
  end

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_errors_at_start) begin
      tests_failed++;
      $display("%s: FAIL (%0d errors)", cur_test, errors - test_errors_at_start);
    end else begin
      $display("%s: PASS", cur_test);
    end
  endtask

  task automatic send_beat(input pcap_beat_t beat);
    s_axis_beat   = beat;
    s_axis_tvalid = 1'b1;
    @(negedge axis_aclk);
    while (!s_axis_tready) @(negedge axis_aclk);
    @(posedge axis_aclk);
    #1;
    s_axis_tvalid = 1'b0;
  endtask

  // Records n beats with the first packet ending at beat split-1
  task automatic record_trace(input int n, input int split);
    pcap_beat_t beat;
    rec_q.delete();
    for (int i = 0; i < n; i++) begin
      beat.tdata = {$urandom, $urandom};
      beat.tlast = (i == split - 1) || (i == n - 1);
      beat.tkeep = beat.tlast ? 8'h0f : 8'hff;
      rec_q.push_back(beat);
      send_beat(beat);
    end
    wr_done = 1'b1;
    @(posedge axis_aclk);
    #1;
    wr_done = 1'b0;
    repeat (3) @(posedge axis_aclk);
    #1;
  endtask

  task automatic pulse_start(input int count);
    replay_count = count[`REPLAY_COUNT_W-1:0];
    replay_start = 1'b1;
    repeat (2) @(posedge axis_aclk);
    #1;
    replay_start = 1'b0;
  endtask

  task automatic run_replay(input int count);
    for (int p = 0; p < count; p++) begin
      foreach (rec_q[i]) exp_q.push_back(rec_q[i]);
    end
    pulse_start(count);
    @(negedge axis_aclk);
    while (replay_busy || exp_q.size() != 0) @(negedge axis_aclk);
    // Quiet window to catch extra beats
    repeat (20) @(negedge axis_aclk);
    assert (!replay_busy && !m_axis_tvalid) else begin
      $display("%s: engine still active after the replay ended", cur_test);
      errors++;
    end
    @(posedge axis_aclk);
    #1;
  endtask

  initial begin
    void'($urandom(79));
    axis_aresetn  = 1'b0;
    sw_rst        = 1'b0;
    wr_done       = 1'b0;
    replay_start  = 1'b0;
    replay_count  = '0;
    s_axis_beat   = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    ready_mode    = 1;
    draining      = 1'b0;
    expect_idle   = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    drained       = 0;
    cur_test      = "reset";
    repeat (3) @(posedge axis_aclk);
    #1;
    axis_aresetn = 1'b1;

    begin_test("reset_state");
    @(negedge axis_aclk);
    assert (!m_axis_tvalid && !replay_busy && s_axis_tready) else begin
      $display("%s: outputs not idle after reset", cur_test);
      errors++;
    end
    @(posedge axis_aclk);
    #1;
    end_test();

    begin_test("replay_once");
    record_trace(5, 2);
    run_replay(1);
    end_test();

    begin_test("replay_three");
    run_replay(3);
    end_test();

    begin_test("backpressure_four");
    record_trace(12, 5);
    ready_mode = 2;
    run_replay(4);
    ready_mode = 1;
    end_test();

    begin_test("zero_count");
    expect_idle = 1'b1;
    pulse_start(0);
    repeat (30) @(posedge axis_aclk);
    #1;
    expect_idle = 1'b0;
    end_test();

    begin_test("sw_reset_midreplay");
    draining   = 1'b1;
    ready_mode = 0;
    pulse_start(4);
    repeat (30) @(posedge axis_aclk);
    #1;
    sw_rst = 1'b1;
    @(posedge axis_aclk);
    #1;
    sw_rst = 1'b0;
    @(negedge axis_aclk);
    assert (!replay_busy) else begin
      $display("%s: replay still busy after software reset", cur_test);
      errors++;
    end
    ready_mode = 1;
    while (m_axis_tvalid) @(negedge axis_aclk);
    repeat (4) @(negedge axis_aclk);
    draining = 1'b0;
    @(posedge axis_aclk);
    #1;
    record_trace(3, 3);
    run_replay(1);
    end_test();

    $display("Tests run %0d, tests failed %0d, errors %0d, drained beats %0d",
             tests_run, tests_failed, errors, drained);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
